// ==== design/fifo_config.svh ====
// Build-time sizing for the AXI4-Stream FIFO
// Storage depth, pointer width, beat width and sideband widths

`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// --------------------------------------------------
// Storage
// --------------------------------------------------

// Entries in the array, power of two so pointers wrap by themselves
`define FIFO_DEPTH 16

// Address bits for one entry of the array
`define FIFO_ADDR_WID $clog2(`FIFO_DEPTH)

// --------------------------------------------------
// Stream fields
// --------------------------------------------------

// Bytes per beat on tdata
`define FIFO_DATA_BYTES 4

// Sideband widths
`define FIFO_TID_WID 2
`define FIFO_TDEST_WID 2
`define FIFO_TUSER_WID 1

`endif

// ==== design/axi4s_pkg.sv ====
// AXI4-Stream field types for the FIFO
// Per-field typedefs, the packed field struct, and the entry word
// that is stored either as a flat vector or as fields

`default_nettype none

`include "fifo_config.svh"

package axi4s_pkg;

    // Payload, byte-addressable
    typedef logic [`FIFO_DATA_BYTES-1:0][7:0] tdata_t;
    // One strobe per byte
    typedef logic [`FIFO_DATA_BYTES-1:0]      tkeep_t;

    // Sideband fields
    typedef logic [`FIFO_TID_WID-1:0]   tid_t;
    typedef logic [`FIFO_TDEST_WID-1:0] tdest_t;
    typedef logic [`FIFO_TUSER_WID-1:0] tuser_t;

    // All fields of one beat, tdata in the top bits
    typedef struct packed {
        tdata_t tdata;
        tkeep_t tkeep;
        logic   tlast;
        tid_t   tid;
        tdest_t tdest;
        tuser_t tuser;
    } axi4s_fields_t;

    // Width of one stored word, 42 bits with the default sizes
    localparam int ENTRY_WID = $bits(axi4s_fields_t);

    // Stored word
    // Memory sees a flat vector, the stream side sees fields
    typedef union packed {
        logic [ENTRY_WID-1:0] raw;
        axi4s_fields_t        fields;
    } fifo_entry_t;

endpackage : axi4s_pkg

`default_nettype wire

// ==== design/fifo_pkg.sv ====
// FIFO control types
// Optimisation mode selector and the output stage states

`default_nettype none

package fifo_pkg;

    // Timing mode puts a register after the array
    // Latency mode reads the array straight to the port
    typedef enum logic {
        OPT_MODE_TIMING  = 1'b0,
        OPT_MODE_LATENCY = 1'b1
    } opt_mode_t;

    // Output stage occupancy
    // OUT_EMPTY  nothing presented
    // OUT_LOAD   word moving from array into output register
    // OUT_HOLD   word presented on the master side
    typedef enum logic [1:0] {
        OUT_EMPTY = 2'd0,
        OUT_LOAD  = 2'd1,
        OUT_HOLD  = 2'd2
    } out_state_t;

endpackage : fifo_pkg

`default_nettype wire

// ==== design/fifo_ptr_counter.sv ====
// FIFO pointer and occupancy tracking
// Wrapping write and read pointers, entry count with push and pop
// in the same cycle, and registered empty and full flags

`default_nettype none

`include "fifo_config.svh"

module fifo_ptr_counter #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                     aclk,
    input  logic                     arst_n,

    // Strobes from the controller
    input  logic                     wr_en,
    input  logic                     rd_en,

    // Array addresses
    output logic [$clog2(DEPTH)-1:0] wr_addr,
    output logic [$clog2(DEPTH)-1:0] rd_addr,

    // Occupancy flags
    output logic                     empty,
    output logic                     full
);

    // Count needs one extra code to tell full from empty
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic [CNT_WID-1:0] count;
    logic [CNT_WID-1:0] count_nxt;

    // --------------------------------------------------
    // Next occupancy
    // --------------------------------------------------
    always_comb begin
        count_nxt = count;
        case ({wr_en, rd_en})
            // Push only
            2'b10:   count_nxt = count + 1'b1;
            // Pop only
            2'b01:   count_nxt = count - 1'b1;
            // Idle, or push and pop cancel out
            default: count_nxt = count;
        endcase
    end

    // --------------------------------------------------
    // Pointers, count and flags
    // --------------------------------------------------
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_addr <= '0;
            rd_addr <= '0;
            count   <= '0;
            empty   <= 1'b1;
            full    <= 1'b0;
        end else begin
            // Power-of-two depth, pointers wrap on overflow
            if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (rd_en) begin
                rd_addr <= rd_addr + 1'b1;
            end

            count <= count_nxt;

            // Flags follow the count after this edge
            empty <= (count_nxt == '0);
            full  <= (count_nxt == CNT_WID'(DEPTH));
        end
    end

endmodule : fifo_ptr_counter

`default_nettype wire

// ==== design/fifo_mem.sv ====
// FIFO entry storage
// Array of raw entry words with a registered write port, and a read
// port that is either registered (timing mode) or direct (latency mode)

`default_nettype none

`include "fifo_config.svh"

module fifo_mem
    import axi4s_pkg::*, fifo_pkg::*;
#(
    parameter opt_mode_t OPT_MODE = OPT_MODE_TIMING
) (
    input  logic                      aclk,
    input  logic                      arst_n,

    // Write port
    input  logic                      wr_en,
    input  logic [`FIFO_ADDR_WID-1:0] wr_addr,
    input  fifo_entry_t               wr_data,

    // Read port
    input  logic [`FIFO_ADDR_WID-1:0] rd_addr,
    input  logic                      out_load,
    output fifo_entry_t               rd_data
);

    // Storage, raw view only
    logic [ENTRY_WID-1:0] mem_array [`FIFO_DEPTH];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem_array[wr_addr] <= wr_data.raw;
        end
    end

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    if (OPT_MODE == OPT_MODE_TIMING) begin : g_out_reg
        logic [ENTRY_WID-1:0] out_q;

        // Loaded by the controller when a word is popped
        always_ff @(posedge aclk or negedge arst_n) begin
            if (!arst_n) begin
                out_q <= '0;
            end else if (out_load) begin
                out_q <= mem_array[rd_addr];
            end
        end

        assign rd_data.raw = out_q;
    end else begin : g_comb_rd
        // Head of the array straight to the output
        assign rd_data.raw = mem_array[rd_addr];
    end

endmodule : fifo_mem

`default_nettype wire

// ==== design/fifo_ctrl.sv ====
// FIFO output stage controller
// Slave-side ready and write strobe from the full flag, and an FSM
// that tracks the output stage and issues pops and output loads

`default_nettype none

module fifo_ctrl
    import fifo_pkg::*;
#(
    parameter opt_mode_t OPT_MODE = OPT_MODE_TIMING
) (
    input  logic aclk,
    input  logic arst_n,

    // Stream handshake inputs
    input  logic s_tvalid,
    input  logic m_tready,

    // Array flags from the counter
    input  logic empty,
    input  logic full,

    // Stream handshake outputs
    output logic s_tready,
    output logic m_tvalid,

    // Strobes to counter and memory
    output logic wr_en,
    output logic rd_en,
    output logic out_load
);

    // Registered output stage in front of the master port
    localparam bit TIMING = (OPT_MODE == OPT_MODE_TIMING);

    out_state_t state;
    out_state_t state_nxt;

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------

    // Accept while the array has room
    assign s_tready = ~full;
    assign wr_en    = s_tvalid & ~full;

    // --------------------------------------------------
    // Output stage FSM
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        m_tvalid  = 1'b0;
        rd_en     = 1'b0;
        out_load  = 1'b0;

        case (state)
            OUT_EMPTY: begin
                // Word waiting in the array
                if (!empty) begin
                    state_nxt = TIMING ? OUT_LOAD : OUT_HOLD;
                end
            end

            OUT_LOAD: begin
                // Pop head into the output register, one cycle only
                rd_en     = 1'b1;
                out_load  = 1'b1;
                state_nxt = OUT_HOLD;
            end

            OUT_HOLD: begin
                if (TIMING) begin
                    // Output register is full
                    m_tvalid = 1'b1;
                    if (m_tready) begin
                        if (!empty) begin
                            // Refill in the same cycle, no bubble
                            rd_en    = 1'b1;
                            out_load = 1'b1;
                        end else begin
                            state_nxt = OUT_EMPTY;
                        end
                    end
                end else begin
                    // Head of the array is the output word
                    // Goes empty only right after the last pop
                    m_tvalid = ~empty;
                    rd_en    = m_tready & ~empty;
                    if (empty) begin
                        state_nxt = OUT_EMPTY;
                    end
                end
            end

            default: begin
                state_nxt = OUT_EMPTY;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= OUT_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

endmodule : fifo_ctrl

`default_nettype wire

// ==== design/axi4s_fifo_core.sv ====
// Word-based AXI4-Stream FIFO, single clock
// Packs the slave fields into one entry word, buffers it first-word
// fall-through, and unpacks it onto the master side
// Holds the pointer counter, the storage and the output controller

`default_nettype none

`include "fifo_config.svh"

module axi4s_fifo_core
    import axi4s_pkg::*, fifo_pkg::*;
#(
    parameter opt_mode_t FIFO_OPT_MODE = OPT_MODE_TIMING
) (
    input  logic   aclk,
    input  logic   arst_n,

    // Slave side
    input  logic   s_tvalid,
    output logic   s_tready,
    input  tdata_t s_tdata,
    input  tkeep_t s_tkeep,
    input  logic   s_tlast,
    input  tid_t   s_tid,
    input  tdest_t s_tdest,
    input  tuser_t s_tuser,

    // Master side
    output logic   m_tvalid,
    input  logic   m_tready,
    output tdata_t m_tdata,
    output tkeep_t m_tkeep,
    output logic   m_tlast,
    output tid_t   m_tid,
    output tdest_t m_tdest,
    output tuser_t m_tuser
);

    fifo_entry_t wr_entry;
    fifo_entry_t rd_entry;

    logic wr_en;
    logic rd_en;
    logic out_load;
    logic empty;
    logic full;

    logic [`FIFO_ADDR_WID-1:0] wr_addr;
    logic [`FIFO_ADDR_WID-1:0] rd_addr;

    // --------------------------------------------------
    // Stream fields to and from the entry word
    // --------------------------------------------------
    always_comb begin
        wr_entry.fields.tdata = s_tdata;
        wr_entry.fields.tkeep = s_tkeep;
        wr_entry.fields.tlast = s_tlast;
        wr_entry.fields.tid   = s_tid;
        wr_entry.fields.tdest = s_tdest;
        wr_entry.fields.tuser = s_tuser;
    end

    assign m_tdata = rd_entry.fields.tdata;
    assign m_tkeep = rd_entry.fields.tkeep;
    assign m_tlast = rd_entry.fields.tlast;
    assign m_tid   = rd_entry.fields.tid;
    assign m_tdest = rd_entry.fields.tdest;
    assign m_tuser = rd_entry.fields.tuser;

    // --------------------------------------------------
    // FIFO blocks
    // --------------------------------------------------

    // Addresses and flags
    fifo_ptr_counter #(
        .DEPTH   (`FIFO_DEPTH)
    ) u_ptr_counter (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .empty   (empty),
        .full    (full)
    );

    // Storage and read path
    fifo_mem #(
        .OPT_MODE (FIFO_OPT_MODE)
    ) u_mem (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_entry),
        .rd_addr  (rd_addr),
        .out_load (out_load),
        .rd_data  (rd_entry)
    );

    // Handshakes and strobes
    fifo_ctrl #(
        .OPT_MODE (FIFO_OPT_MODE)
    ) u_ctrl (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tvalid (s_tvalid),
        .m_tready (m_tready),
        .empty    (empty),
        .full     (full),
        .s_tready (s_tready),
        .m_tvalid (m_tvalid),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .out_load (out_load)
    );

endmodule : axi4s_fifo_core

`default_nettype wire

// ==== tests/fifo_props.sv ====
// Concurrent assertions for the FIFO output controller
// Stall stability of m_tvalid and the FSM, a full array that only
// drains through a pop, and a one-cycle OUT_LOAD from a non-empty array

`default_nettype none

module fifo_props
    import fifo_pkg::*;
(
    input logic       aclk,
    input logic       arst_n,
    input logic       m_tvalid,
    input logic       m_tready,
    input logic       wr_en,
    input logic       rd_en,
    input logic       empty,
    input logic       full,
    input out_state_t state
);

    // Failed assertions so far
    int fail_count = 0;

    // Stalled output keeps its valid
    a_valid_stall: assert property (@(posedge aclk) disable iff (!arst_n)
        (m_tvalid && !m_tready) |=> m_tvalid)
        else begin
            $error("m_tvalid dropped while the output was stalled");
            fail_count++;
        end

    // Stalled output keeps its FSM state
    a_state_stall: assert property (@(posedge aclk) disable iff (!arst_n)
        (m_tvalid && !m_tready) |=> $stable(state))
        else begin
            $error("Output FSM moved while the output was stalled");
            fail_count++;
        end

    // Full array stays full until a pop
    // A push past full would wrap the count and drop the flag
    a_full_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        (full && !rd_en) |=> full)
        else begin
            $error("Full flag fell without a pop from the array");
            fail_count++;
        end

    // Load pops a real word and lasts one cycle
    a_load_once: assert property (@(posedge aclk) disable iff (!arst_n)
        (state == OUT_LOAD) |-> !empty ##1 (state == OUT_HOLD))
        else begin
            $error("OUT_LOAD on an empty array or for more than one cycle");
            fail_count++;
        end

endmodule : fifo_props

`default_nettype wire

// ==== tests/fifo_checker.sv ====
// Scoreboard for the AXI4-Stream FIFO
// Queue model of accepted beats, per-beat comparison at the output,
// stall hold, s_tready level rules, first-beat latency, final checks

`default_nettype none

`include "fifo_config.svh"

module fifo_checker
    import axi4s_pkg::*;
(
    input  logic   aclk,
    input  logic   arst_n,
    input  int     phase,
    input  logic   end_check,

    input  logic   s_tvalid,
    input  logic   s_tready,
    input  tdata_t s_tdata,
    input  tkeep_t s_tkeep,
    input  logic   s_tlast,
    input  tid_t   s_tid,
    input  tdest_t s_tdest,
    input  tuser_t s_tuser,

    input  logic   m_tvalid,
    input  logic   m_tready,
    input  tdata_t m_tdata,
    input  tkeep_t m_tkeep,
    input  logic   m_tlast,
    input  tid_t   m_tid,
    input  tdest_t m_tdest,
    input  tuser_t m_tuser,

    output int     level,
    output int     error_count
);

    // Array plus the output register in timing mode
    localparam int CAPACITY = `FIFO_DEPTH + 1;

    logic [ENTRY_WID-1:0] model_q [$];
    logic [ENTRY_WID-1:0] in_word;
    logic [ENTRY_WID-1:0] out_word;
    logic [ENTRY_WID-1:0] exp_word;
    logic [ENTRY_WID-1:0] held_word;
    logic                 held_stall = 1'b0;
    logic                 any_accepted = 1'b0;
    logic                 end_done = 1'b0;
    int                   cyc = 0;
    int                   first_due = 0;
    int                   peak = 0;
    int                   errs = 0;
    int                   lvl = 0;

    assign level       = lvl;
    assign error_count = errs;

    function automatic string phase_name(input int p);
        string name;
        case (p)
            0:       name = "reset";
            1:       name = "latency";
            2:       name = "fill";
            3:       name = "drain";
            4:       name = "random";
            5:       name = "final_drain";
            default: name = "unknown";
        endcase
        return name;
    endfunction

    task automatic report_value(input string what, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        errs++;
        $display("Error %s %s expected %0h actual %0h", phase_name(phase), what, exp_v, act_v);
    endtask

    task automatic report_text(input string what);
        errs++;
        $display("Check failed in %s: %s", phase_name(phase), what);
    endtask

    // --------------------------------------------------
    // Per-edge model update and compare
    // --------------------------------------------------
    always @(posedge aclk) begin
        if (!arst_n) begin
            model_q.delete();
            held_stall = 1'b0;
            first_due  = 0;
            lvl       <= 0;
        end else begin
            cyc      = cyc + 1;
            // Field order of the stream entry, tdata on top
            in_word  = {s_tdata, s_tkeep, s_tlast, s_tid, s_tdest, s_tuser};
            out_word = {m_tdata, m_tkeep, m_tlast, m_tid, m_tdest, m_tuser};

            // Quiet outputs until the first beat
            if (!any_accepted && m_tvalid) begin
                report_text("m_tvalid high before any beat was sent");
            end

            // Stalled word stays put
            if (held_stall) begin
                if (!m_tvalid) begin
                    report_text("m_tvalid fell while the output was stalled");
                end else if (out_word !== held_word) begin
                    report_value("hold", 64'(held_word), 64'(out_word));
                end
            end

            // Room in the array means ready, full capacity means not
            if (model_q.size() < `FIFO_DEPTH ||
                (m_tvalid && model_q.size() <= `FIFO_DEPTH)) begin
                if (!s_tready) begin
                    report_value("s_tready", 64'(1'b1), 64'(s_tready));
                end
            end else if (model_q.size() >= CAPACITY && s_tready) begin
                report_value("s_tready", 64'(1'b0), 64'(s_tready));
            end

            // Timing mode, visible after edge N+2, sampled at N+3
            if (first_due != 0) begin
                if (cyc < first_due && m_tvalid) begin
                    report_value("latency m_tvalid early", 64'(1'b0), 64'(m_tvalid));
                end else if (cyc == first_due) begin
                    if (!m_tvalid) begin
                        report_value("latency m_tvalid", 64'(1'b1), 64'(m_tvalid));
                    end
                    first_due = 0;
                end
            end

            // Output beat against the oldest unsent input beat
            if (m_tvalid && m_tready) begin
                if (model_q.size() == 0) begin
                    report_text("output beat with no input beat pending");
                end else begin
                    exp_word = model_q.pop_front();
                    if (out_word !== exp_word) begin
                        report_value("beat", 64'(exp_word), 64'(out_word));
                    end
                end
            end

            if (s_tvalid && s_tready) begin
                // Into an empty FIFO
                if (model_q.size() == 0) begin
                    first_due = cyc + 3;
                end
                model_q.push_back(in_word);
                any_accepted = 1'b1;
                if (model_q.size() > peak) begin
                    peak = model_q.size();
                end
            end

            // Nothing lost, full fill reached
            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (model_q.size() != 0) begin
                    report_value("leftover beats", 64'(0), 64'(model_q.size()));
                end
                if (peak != CAPACITY) begin
                    report_value("fill level", 64'(CAPACITY), 64'(peak));
                end
            end

            held_stall = m_tvalid && !m_tready;
            held_word  = out_word;
            lvl       <= model_q.size();
        end
    end

endmodule : fifo_checker

`default_nettype wire

// ==== tests/tb_axi4s_fifo.sv ====
// Testbench top for the AXI4-Stream FIFO
// Clock and reset, LFSR stimulus, DUT in timing mode, scoreboard,
// controller assertions, watchdog and closing summary

`default_nettype none

`include "fifo_config.svh"

module tb_axi4s_fifo
    import axi4s_pkg::*, fifo_pkg::*;
();

    localparam int LAT_BEATS   = 4;
    localparam int FILL_CYCLES = `FIFO_DEPTH + 12;
    localparam int RAND_BEATS  = 300;
    localparam int NUM_DUTY    = 4;
    // Valid and ready duty out of 4 for each random sub-phase
    localparam int V_DUTY [NUM_DUTY] = '{1, 2, 3, 4};
    localparam int R_DUTY [NUM_DUTY] = '{3, 2, 1, 4};

    // Watchdog bound from the beat count of all phases
    localparam int TOTAL_BEATS     = LAT_BEATS + FILL_CYCLES + RAND_BEATS * NUM_DUTY;
    localparam int CYC_PER_BEAT    = 16;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * CYC_PER_BEAT;

    logic   aclk;
    logic   arst_n;
    logic   s_tvalid;
    logic   s_tready;
    tdata_t s_tdata;
    tkeep_t s_tkeep;
    logic   s_tlast;
    tid_t   s_tid;
    tdest_t s_tdest;
    tuser_t s_tuser;
    logic   m_tvalid;
    logic   m_tready;
    tdata_t m_tdata;
    tkeep_t m_tkeep;
    logic   m_tlast;
    tid_t   m_tid;
    tdest_t m_tdest;
    tuser_t m_tuser;

    int          phase;
    logic        end_check;
    int          level;
    int          error_count;
    int          beats_sent;
    logic [15:0] lfsr_q;

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    axi4s_fifo_core #(
        .FIFO_OPT_MODE (OPT_MODE_TIMING)
    ) u_dut (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tdata  (s_tdata),
        .s_tkeep  (s_tkeep),
        .s_tlast  (s_tlast),
        .s_tid    (s_tid),
        .s_tdest  (s_tdest),
        .s_tuser  (s_tuser),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tkeep  (m_tkeep),
        .m_tlast  (m_tlast),
        .m_tid    (m_tid),
        .m_tdest  (m_tdest),
        .m_tuser  (m_tuser)
    );

    fifo_checker u_checker (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .phase       (phase),
        .end_check   (end_check),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .s_tdata     (s_tdata),
        .s_tkeep     (s_tkeep),
        .s_tlast     (s_tlast),
        .s_tid       (s_tid),
        .s_tdest     (s_tdest),
        .s_tuser     (s_tuser),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tlast     (m_tlast),
        .m_tid       (m_tid),
        .m_tdest     (m_tdest),
        .m_tuser     (m_tuser),
        .level       (level),
        .error_count (error_count)
    );

    bind fifo_ctrl fifo_props u_props (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .empty    (empty),
        .full     (full),
        .state    (state)
    );

    // --------------------------------------------------
    // Random source
    // --------------------------------------------------

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic present_new_beat();
        logic [31:0] r;
        take_bits(32, r);
        s_tdata <= r;
        take_bits(10, r);
        s_tkeep  <= r[9:6];
        s_tlast  <= r[5];
        s_tid    <= r[4:3];
        s_tdest  <= r[2:1];
        s_tuser  <= r[0];
        s_tvalid <= 1'b1;
    endtask

    // One clock of traffic just after a rising edge
    task automatic run_cycle(input int v_duty, input int r_duty);
        logic [31:0] r;
        if (s_tvalid && s_tready) begin
            beats_sent++;
        end
        // Presented beat stays until taken
        if (!s_tvalid || s_tready) begin
            take_bits(2, r);
            if (int'(r[1:0]) < v_duty) begin
                present_new_beat();
            end else begin
                s_tvalid <= 1'b0;
            end
        end
        take_bits(2, r);
        m_tready <= (int'(r[1:0]) < r_duty);
    endtask

    task automatic send_one_beat();
        @(posedge aclk);
        present_new_beat();
        m_tready <= 1'b1;
        @(posedge aclk);
        while (!s_tready) begin
            @(posedge aclk);
        end
        s_tvalid <= 1'b0;
        @(posedge aclk);
        while (level != 0) begin
            @(posedge aclk);
        end
        repeat (2) @(posedge aclk);
    endtask

    // Stop new input and empty the FIFO
    task automatic drain_all();
        @(posedge aclk);
        run_cycle(0, 4);
        while (level != 0 || s_tvalid) begin
            @(posedge aclk);
            run_cycle(0, 4);
        end
        repeat (4) begin
            @(posedge aclk);
            run_cycle(0, 4);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int total_errors;
        s_tvalid   = 1'b0;
        s_tdata    = '0;
        s_tkeep    = '0;
        s_tlast    = 1'b0;
        s_tid      = '0;
        s_tdest    = '0;
        s_tuser    = '0;
        m_tready   = 1'b0;
        arst_n     = 1'b0;
        phase      = 0;
        end_check  = 1'b0;
        beats_sent = 0;
        lfsr_q     = 16'd2;

        repeat (2) @(posedge aclk);
        arst_n <= 1'b1;
        // Idle with quiet outputs
        repeat (6) @(posedge aclk);

        phase <= 1;
        for (int i = 0; i < LAT_BEATS; i++) begin
            send_one_beat();
        end

        // Output stalled with input always valid
        phase <= 2;
        repeat (FILL_CYCLES) begin
            @(posedge aclk);
            run_cycle(4, 0);
        end

        phase <= 3;
        drain_all();

        phase <= 4;
        for (int d = 0; d < NUM_DUTY; d++) begin
            beats_sent = 0;
            while (beats_sent < RAND_BEATS) begin
                @(posedge aclk);
                run_cycle(V_DUTY[d], R_DUTY[d]);
            end
        end

        phase <= 5;
        drain_all();
        end_check <= 1'b1;
        @(posedge aclk);
        end_check <= 1'b0;
        repeat (2) @(posedge aclk);

        total_errors = error_count + u_dut.u_ctrl.u_props.fail_count;
        $display("Summary: %0d scoreboard errors, %0d assertion failures",
                 error_count, u_dut.u_ctrl.u_props.fail_count);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Watchdog expired after %0d cycles, the test sequence did not complete",
                 WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_axi4s_fifo

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/axi4s_pkg.sv
design/fifo_pkg.sv
design/fifo_ptr_counter.sv
design/fifo_mem.sv
design/fifo_ctrl.sv
design/axi4s_fifo_core.sv
tests/fifo_props.sv
tests/fifo_checker.sv
tests/tb_axi4s_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the AXI4-Stream FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -j 0 \
    --top-module tb_axi4s_fifo \
    -f sources.f \
    -o sim_axi4s_fifo

# Assertion errors must not stop the run before the summary
./obj_dir/sim_axi4s_fifo +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx '\*\*\* PASSED \*\*\*' sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
